/* hw/i2c_bus_pkg.sv */
`default_nettype none
// i2c bus constants
// device address, bit-slot length, R/W bit values and the frame kinds
// that the sequencer hands to the byte engine

package i2c_bus_pkg;

    //************************************************************
    // device and bit timing
    //************************************************************

    localparam logic [6:0] slave_addr = 7'b1010000;     // eeprom device address

    localparam int unsigned phases_per_bit = 4;          // dri_clk cycles per scl bit

    localparam logic rw_write = 1'b0;                    // r/w bit for writes
    localparam logic rw_read  = 1'b1;                    // r/w bit for reads

    //************************************************************
    // frame kinds run by the byte engine
    //************************************************************

    typedef enum logic [1:0] {
        fk_start_byte = 2'd0,    // (repeated) start, 8 bits, ack slot
        fk_byte       = 2'd1,    // 8 bits written, ack slot
        fk_read_byte  = 2'd2,    // 8 bits sampled, master nack
        fk_stop       = 2'd3     // stop condition
    } frame_kind_t;

endpackage : i2c_bus_pkg

`default_nettype wire

/* hw/i2c_cmd_pkg.sv */
`default_nettype none
// i2c command interface types
// the command word taken by the controller and the response it returns

package i2c_cmd_pkg;

    // one eeprom access, exec is a level sampled while idle
    typedef struct packed {
        logic        exec;       // request
        logic        rd;         // 1 read, 0 write
        logic        addr16;     // two-byte word address
        logic [15:0] addr;       // word address
        logic [7:0]  wdata;      // byte to write
    } i2c_cmd_t;

    // result of the last access
    typedef struct packed {
        logic        done;       // one-cycle pulse
        logic        nack;       // sticky, any slave ack slot high
        logic [7:0]  rdata;      // byte read
    } i2c_rsp_t;

endpackage : i2c_cmd_pkg

`default_nettype wire

/* hw/i2c_byte_engine.sv */
`default_nettype none
// i2c byte engine
// drives scl and sda for one frame in four-cycle bit slots and samples
// the ack slot and read bits

module i2c_byte_engine
    import i2c_bus_pkg::*;
(
    input  logic        dri_clk,
    input  logic        rst_n,
    input  logic        start,
    input  frame_kind_t kind,
    input  logic [7:0]  tx_byte,
    input  logic        sda_i,
    output logic        scl,
    output logic        sda_oe,
    output logic        sda_o,
    output logic        frame_done,
    output logic        ack_bit,
    output logic [7:0]  rx_byte
);

    logic        busy;           // frame in flight
    logic [5:0]  cnt;            // cycles into the frame
    frame_kind_t kind_q;
    logic [7:0]  tx_sh;          // bits left to send, msb first
    logic [7:0]  rx_sh;
    logic [5:0]  off;            // start frames carry one extra slot
    logic [5:0]  lc;             // cycle inside the byte part
    logic [1:0]  phase;
    logic [3:0]  slot;           // 0..7 data, 8 ack
    logic        in_prologue;
    logic        wr_kind;
    logic        bit_load;       // put next tx bit on sda
    logic        bit_sample;     // shift sda_i into rx

    assign off         = (kind_q == fk_start_byte) ? 6'(phases_per_bit) : 6'd0;
    assign lc          = cnt - off;
    assign phase       = 2'(lc % phases_per_bit);
    assign slot        = 4'(lc / phases_per_bit);
    assign in_prologue = (kind_q == fk_start_byte) && (cnt < off);
    assign wr_kind     = (kind_q != fk_read_byte);

    assign bit_load = busy && ((kind_q == fk_start_byte) || (kind_q == fk_byte)) &&
                      (in_prologue ? (cnt == 6'd3) : ((phase == 2'd3) && (slot < 4'd7)));
    assign bit_sample = busy && (kind_q == fk_read_byte) && (phase == 2'd1) && (slot < 4'd8);

    assign rx_byte = rx_sh;

    //************************************************************
    // scl / sda sequencing
    //************************************************************

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            cnt        <= 6'd0;
            kind_q     <= fk_stop;
            scl        <= 1'b1;
            sda_oe     <= 1'b0;
            sda_o      <= 1'b1;
            frame_done <= 1'b0;
            ack_bit    <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy   <= 1'b1;
                    cnt    <= 6'd0;
                    kind_q <= kind;
                    sda_oe <= (kind != fk_read_byte);    // reads let the slave drive
                    case (kind)
                        fk_byte: sda_o <= tx_byte[7];    // first bit, scl already low
                        fk_stop: sda_o <= 1'b0;          // low before scl rises
                        default: sda_o <= 1'b1;          // sda high ahead of start
                    endcase
                end
            end else begin
                cnt <= cnt + 6'd1;
                if (kind_q == fk_stop) begin
                    case (cnt)
                        6'd0: scl <= 1'b1;
                        6'd2: begin                      // sda rises with scl high
                            sda_oe <= 1'b0;
                            sda_o  <= 1'b1;
                        end
                        6'd14: frame_done <= 1'b1;
                        6'd15: busy <= 1'b0;
                        default: ;
                    endcase
                end else if (in_prologue) begin
                    case (cnt[1:0])
                        2'd0: scl <= 1'b1;
                        2'd1: sda_o <= 1'b0;             // start condition
                        2'd2: scl <= 1'b0;
                        default: ;                       // first bit via bit_load
                    endcase
                end else begin
                    case (phase)
                        2'd0: scl <= 1'b1;
                        2'd1: begin
                            if (slot == 4'd8) begin
                                frame_done <= 1'b1;
                                if (wr_kind)
                                    ack_bit <= sda_i;    // high means no ack
                            end
                        end
                        2'd2: begin
                            scl <= 1'b0;
                            if (slot == 4'd8)
                                busy <= 1'b0;
                        end
                        default: begin
                            if (slot == 4'd7) begin      // hand over for the ack slot
                                sda_oe <= !wr_kind;      // master nack on reads
                                sda_o  <= 1'b1;
                            end
                        end
                    endcase
                end
                if (bit_load)
                    sda_o <= tx_sh[7];
            end
        end
    end

    // shift registers for the byte itself
    always_ff @(posedge dri_clk) begin
        if (!busy && start)
            tx_sh <= (kind == fk_byte) ? {tx_byte[6:0], 1'b0} : tx_byte;
        else if (bit_load)
            tx_sh <= {tx_sh[6:0], 1'b0};
        if (bit_sample)
            rx_sh <= {rx_sh[6:0], sda_i};                // msb arrives first
    end

endmodule : i2c_byte_engine

`default_nettype wire

/* hw/i2c_sequencer.sv */
`default_nettype none
// i2c transaction sequencer
// latches one command, steps the eeprom access frame by frame through
// the byte engine and builds the response

module i2c_sequencer
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
(
    input  logic        dri_clk,
    input  logic        rst_n,
    input  i2c_cmd_t    cmd,
    input  logic        frame_done,
    input  logic        ack_bit,
    input  logic [7:0]  rx_byte,
    output logic        start,
    output frame_kind_t kind,
    output logic [7:0]  tx_byte,
    output i2c_rsp_t    rsp
);

    typedef enum logic [7:0] {
        st_idle    = 8'b0000_0001,
        st_sladdr  = 8'b0000_0010,   // device address, write
        st_addr_hi = 8'b0000_0100,
        st_addr_lo = 8'b0000_1000,
        st_data_wr = 8'b0001_0000,
        st_addr_rd = 8'b0010_0000,   // repeated start, device address, read
        st_data_rd = 8'b0100_0000,
        st_stop    = 8'b1000_0000
    } seq_state_t;

    seq_state_t  state;
    seq_state_t  state_nxt;
    logic        rd_q;
    logic        addr16_q;
    logic [15:0] addr_q;
    logic [7:0]  wdata_q;
    frame_kind_t kind_nxt;
    logic [7:0]  byte_nxt;
    logic        accept;         // command taken this cycle
    logic        issue;          // new frame goes out
    logic        ack_slot;       // running frame ends in a slave ack

    assign accept   = (state == st_idle) && cmd.exec;
    assign issue    = (state_nxt != state) && (state_nxt != st_idle);
    assign ack_slot = (state != st_idle) && (state != st_data_rd) && (state != st_stop);

    //************************************************************
    // state transitions
    //************************************************************

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (cmd.exec) state_nxt = st_sladdr;
            st_sladdr:  if (frame_done) state_nxt = addr16_q ? st_addr_hi : st_addr_lo;
            st_addr_hi: if (frame_done) state_nxt = st_addr_lo;
            st_addr_lo: if (frame_done) state_nxt = rd_q ? st_addr_rd : st_data_wr;
            st_data_wr: if (frame_done) state_nxt = st_stop;
            st_addr_rd: if (frame_done) state_nxt = st_data_rd;
            st_data_rd: if (frame_done) state_nxt = st_stop;
            st_stop:    if (rsp.done) state_nxt = st_idle;   // leave after the done cycle
            default:    state_nxt = st_idle;
        endcase
    end

    // frame and byte for the state being entered
    always_comb begin
        kind_nxt = fk_byte;
        byte_nxt = 8'h00;
        case (state_nxt)
            st_sladdr: begin
                kind_nxt = fk_start_byte;
                byte_nxt = {slave_addr, rw_write};
            end
            st_addr_hi: byte_nxt = addr_q[15:8];
            st_addr_lo: byte_nxt = addr_q[7:0];
            st_data_wr: byte_nxt = wdata_q;
            st_addr_rd: begin
                kind_nxt = fk_start_byte;
                byte_nxt = {slave_addr, rw_read};
            end
            st_data_rd: kind_nxt = fk_read_byte;
            st_stop:    kind_nxt = fk_stop;
            default: ;
        endcase
    end

    //************************************************************
    // control and response
    //************************************************************

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            start <= 1'b0;
            kind  <= fk_stop;
            rsp   <= '0;
        end else begin
            state    <= state_nxt;
            start    <= issue;
            rsp.done <= 1'b0;
            if (issue)
                kind <= kind_nxt;
            if (accept)
                rsp.nack <= 1'b0;                    // fresh command
            else if (frame_done && ack_slot)
                rsp.nack <= rsp.nack | ack_bit;
            if ((state == st_stop) && frame_done) begin
                rsp.done <= 1'b1;
                if (rd_q)
                    rsp.rdata <= rx_byte;            // engine holds the read byte
            end
        end
    end

    // latched command and outgoing byte
    always_ff @(posedge dri_clk) begin
        if (accept) begin
            rd_q     <= cmd.rd;
            addr16_q <= cmd.addr16;
            addr_q   <= cmd.addr;
            wdata_q  <= cmd.wdata;
        end
        if (issue)
            tx_byte <= byte_nxt;
    end

endmodule : i2c_sequencer

`default_nettype wire

/* hw/i2c_master_top.sv */
`default_nettype none
// i2c master top
// joins the sequencer and the byte engine and drives sda open drain

module i2c_master_top
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
(
    input  logic     dri_clk,
    input  logic     rst_n,
    input  i2c_cmd_t cmd,
    output i2c_rsp_t rsp,
    output logic     scl,
    inout  wire      sda
);

    logic        start;
    frame_kind_t kind;
    logic [7:0]  tx_byte;
    logic        frame_done;
    logic        ack_bit;
    logic [7:0]  rx_byte;
    logic        sda_oe;
    logic        sda_o;
    logic        sda_i;

    assign sda   = (sda_oe && !sda_o) ? 1'b0 : 1'bz;    // low or released
    assign sda_i = sda;

    i2c_sequencer u_seq (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .frame_done (frame_done),
        .ack_bit    (ack_bit),
        .rx_byte    (rx_byte),
        .start      (start),
        .kind       (kind),
        .tx_byte    (tx_byte),
        .rsp        (rsp)
    );

    i2c_byte_engine u_engine (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .start      (start),
        .kind       (kind),
        .tx_byte    (tx_byte),
        .sda_i      (sda_i),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_o      (sda_o),
        .frame_done (frame_done),
        .ack_bit    (ack_bit),
        .rx_byte    (rx_byte)
    );

endmodule : i2c_master_top

`default_nettype wire

/* verif/i2c_eeprom_model.sv */
`default_nettype none
// i2c eeprom model
// behavioral slave with a 64K-byte memory, oversamples scl and sda on the
// falling edge of dri_clk and answers the master on the bus

module i2c_eeprom_model
    import i2c_bus_pkg::*;
(
    input  wire  dri_clk,
    input  wire  scl,
    inout  wire  sda,
    input  logic addr16                 // word address width for this transaction
);

    typedef enum logic [2:0] {
        m_idle, m_dev, m_ahi, m_alo, m_wr, m_rd, m_done
    } model_mode_t;

    logic [7:0]  mem [0:65535];
    model_mode_t mode;
    logic        scl_q;
    logic        sda_q;
    logic        drv;                   // pull sda low
    logic        ackph;                 // inside the ack slot
    logic        rd_next;               // data goes out after this ack
    logic [3:0]  bcnt;
    logic [3:0]  sent;
    logic [7:0]  sh;
    logic [7:0]  rbyte;
    logic [15:0] ptr;

    assign sda = drv ? 1'b0 : 1'bz;

    //************************************************************
    // memory fill and reset values
    //************************************************************

    initial begin
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a = 16'(i);
            mem[i] = a[7:0] ^ a[15:8] ^ 8'h5a;      // every address bit counts
        end
        mode = m_idle;
        scl_q = 1'b1;
        sda_q = 1'b1;
        drv = 1'b0;
        ackph = 1'b0;
        rd_next = 1'b0;
        bcnt = 4'd0;
        sent = 4'd0;
        sh = 8'h00;
        rbyte = 8'h00;
        ptr = 16'h0000;
    end

    // answer a full byte, ack unless refused
    task automatic take_byte();
        logic ack;
        ack = 1'b1;
        case (mode)
            m_dev: begin
                if (sh[7:1] != slave_addr) begin
                    ack = 1'b0;
                    mode = m_idle;
                end else if (sh[0] == rw_read) begin
                    rd_next = 1'b1;
                    mode = m_rd;
                end else begin
                    mode = addr16 ? m_ahi : m_alo;
                end
            end
            m_ahi: begin
                ptr[15:8] = sh;
                mode = m_alo;
            end
            m_alo: begin
                ptr[7:0] = sh;
                if (!addr16)
                    ptr[15:8] = 8'h00;
                mode = m_wr;
            end
            m_wr: begin
                if (ptr[7:0] == 8'hff)
                    ack = 1'b0;                      // refused, memory unchanged
                else
                    mem[ptr] = sh;
                mode = m_done;
            end
            default: ack = 1'b0;
        endcase
        drv = ack;
        ackph = 1'b1;
    endtask

    //************************************************************
    // bus sampling
    //************************************************************

    always @(negedge dri_clk) begin
        if (scl_q && scl && sda_q && !sda) begin            // start or repeated start
            mode = m_dev;
            bcnt = 4'd0;
            drv = 1'b0;
            ackph = 1'b0;
            rd_next = 1'b0;
        end else if (scl_q && scl && !sda_q && sda) begin   // stop
            mode = m_idle;
            drv = 1'b0;
            ackph = 1'b0;
        end else if (!scl_q && scl) begin
            if (!ackph && (mode inside {m_dev, m_ahi, m_alo, m_wr})) begin
                sh = {sh[6:0], sda};
                bcnt = bcnt + 4'd1;
            end
        end else if (scl_q && !scl) begin
            if (ackph) begin
                ackph = 1'b0;
                drv = 1'b0;
                if (rd_next) begin
                    rd_next = 1'b0;
                    rbyte = mem[ptr];
                    drv = !rbyte[7];                 // first read bit
                    sent = 4'd1;
                end
            end else if (mode == m_rd) begin
                if (sent < 4'd8) begin
                    drv = !rbyte[3'(7 - sent)];
                    sent = sent + 4'd1;
                end else begin
                    drv = 1'b0;                      // master nack slot
                    mode = m_done;
                end
            end else if (bcnt == 4'd8) begin
                bcnt = 4'd0;
                take_byte();
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule : i2c_eeprom_model

`default_nettype wire

/* verif/i2c_checker.sv */
`default_nettype none
// i2c response checker
// compares each done with the expected response and watches the idle bus

module i2c_checker
    import i2c_cmd_pkg::*;
(
    input  wire         dri_clk,
    input  wire         rst_n,
    input  i2c_cmd_t    cmd,
    input  i2c_rsp_t    rsp,
    input  wire         scl,
    input  wire         sda,
    input  logic        exp_nack,
    input  logic [7:0]  exp_rdata,
    output int          mismatches,
    output int          others,
    output int          dones
);

    initial begin
        mismatches = 0;
        others = 0;
        dones = 0;
    end

    // sampled mid-cycle away from the driving edge
    always @(negedge dri_clk) begin
        if (rst_n) begin
            if (rsp.done) begin
                dones++;
                if (!cmd.exec) begin
                    $display("error at %0t: done pulse with no command pending", $time);
                    others++;
                end
                if (rsp.nack !== exp_nack) begin
                    $display("MISMATCH t=%0t rsp.nack expected %0d got %0d",
                             $time, exp_nack, rsp.nack);
                    mismatches++;
                end
                if (cmd.rd && (rsp.rdata !== exp_rdata)) begin
                    $display("MISMATCH t=%0t rsp.rdata expected %02h got %02h",
                             $time, exp_rdata, rsp.rdata);
                    mismatches++;
                end
            end else if (!cmd.exec && ((scl !== 1'b1) || (sda !== 1'b1))) begin
                $display("error at %0t: bus not idle between commands (scl %b sda %b)",
                         $time, scl, sda);
                others++;
            end
        end
    end

endmodule : i2c_checker

`default_nettype wire

/* verif/tb_top.sv */
`default_nettype none
// i2c master testbench
// runs a table of eeprom writes and reads against the controller and
// the eeprom model, then reports the error count

module tb_top
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
;

    typedef struct packed {
        logic        rd;
        logic        addr16;
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        nack;       // expected
        logic [7:0]  rdata;      // expected on reads only
    } row_t;

    localparam int n_rows = 9;

    logic       dri_clk;
    logic       rst_n;
    i2c_cmd_t   cmd;
    i2c_rsp_t   rsp;
    logic       addr16_mode;
    logic       exp_nack;
    logic [7:0] exp_rdata;
    wire        scl;
    wire        sda;
    int         mismatches;
    int         others;
    int         dones;
    int         count_errors;    // done count wrong at the end
    row_t       rows [0:n_rows-1];

    pullup (sda);                                    // open-drain bus

    i2c_master_top dut0 (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .cmd     (cmd),
        .rsp     (rsp),
        .scl     (scl),
        .sda     (sda)
    );

    i2c_eeprom_model eeprom0 (
        .dri_clk (dri_clk),
        .scl     (scl),
        .sda     (sda),
        .addr16  (addr16_mode)
    );

    i2c_checker checker0 (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .rsp        (rsp),
        .scl        (scl),
        .sda        (sda),
        .exp_nack   (exp_nack),
        .exp_rdata  (exp_rdata),
        .mismatches (mismatches),
        .others     (others),
        .dones      (dones)
    );

    //************************************************************
    // clock, watchdog
    //************************************************************

    initial begin
        dri_clk = 1'b0;
        forever #4 dri_clk = ~dri_clk;
    end

    initial begin
        #(n_rows * 300 * 8);
        $display("watchdog timeout: transaction did not finish");
        $display("TEST FAIL");
        $finish;
    end

    //************************************************************
    // stimulus table and loop
    //************************************************************

    initial begin
        // memory fill is addr low ^ addr high ^ 5a
        rows[0] = '{1'b0, 1'b0, 16'h0034, 8'ha5, 1'b0, 8'h00};
        rows[1] = '{1'b1, 1'b0, 16'h0034, 8'h00, 1'b0, 8'ha5};
        rows[2] = '{1'b0, 1'b1, 16'h1234, 8'h3c, 1'b0, 8'h00};
        rows[3] = '{1'b1, 1'b1, 16'h1234, 8'h00, 1'b0, 8'h3c};
        rows[4] = '{1'b1, 1'b1, 16'h5634, 8'h00, 1'b0, 8'h38};   // other high byte
        rows[5] = '{1'b0, 1'b1, 16'h12ff, 8'h77, 1'b1, 8'h00};   // refused write
        rows[6] = '{1'b1, 1'b1, 16'h12ff, 8'h00, 1'b0, 8'hb7};
        rows[7] = '{1'b0, 1'b0, 16'h00ff, 8'h11, 1'b1, 8'h00};
        rows[8] = '{1'b1, 1'b0, 16'h00ff, 8'h00, 1'b0, 8'ha5};

        rst_n = 1'b0;
        cmd = '0;
        addr16_mode = 1'b0;
        exp_nack = 1'b0;
        exp_rdata = 8'h00;
        count_errors = 0;
        repeat (3) @(posedge dri_clk);
        rst_n <= 1'b1;
        repeat (20) @(posedge dri_clk);              // idle bus after reset

        for (int i = 0; i < n_rows; i++) begin
            @(posedge dri_clk);
            cmd.exec    <= 1'b1;
            cmd.rd      <= rows[i].rd;
            cmd.addr16  <= rows[i].addr16;
            cmd.addr    <= rows[i].addr;
            cmd.wdata   <= rows[i].wdata;
            addr16_mode <= rows[i].addr16;
            exp_nack    <= rows[i].nack;
            exp_rdata   <= rows[i].rdata;
            do
                @(posedge dri_clk);
            while (!rsp.done);
            cmd.exec <= 1'b0;
            repeat (6) @(posedge dri_clk);           // bus must sit idle here
        end

        if (dones != n_rows) begin
            $display("error: %0d done pulses seen for %0d commands", dones, n_rows);
            count_errors = 1;
        end
        $display("errors: %0d mismatches, %0d other failures",
                 mismatches, others + count_errors);
        if ((mismatches == 0) && (others == 0) && (count_errors == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_top

`default_nettype wire

/* tb.f */
hw/i2c_bus_pkg.sv
hw/i2c_cmd_pkg.sv
hw/i2c_byte_engine.sv
hw/i2c_sequencer.sv
hw/i2c_master_top.sv
verif/i2c_eeprom_model.sv
verif/i2c_checker.sv
verif/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the i2c master testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_top -f tb.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
